// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -sv -Wall
TOP       ?= tb_fetch_frontend
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "all tests passed" $(LOG) && echo "PASS" || (echo "FAIL" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: rtl/bp_lookup_if.sv
`timescale 1ns/1ps

interface bp_lookup_if
    import isa_pkg::*, frontend_pkg::*;
();

    logic            lookup_en;     // one cycle, on request accept
    logic [XLEN-1:0] lookup_pc;
    ghr_t            lookup_ghr;

    // registered results, held until the next lookup
    logic [XLEN-1:0] btb_target;
    logic            btb_hit;
    pht_ctr_t        pht_ctr;
    logic            pht_hit;

    modport requester (
        output lookup_en, lookup_pc, lookup_ghr,
        input  btb_target, btb_hit, pht_ctr, pht_hit
    );

    modport responder (
        input  lookup_en, lookup_pc, lookup_ghr,
        output btb_target, btb_hit, pht_ctr, pht_hit
    );

endinterface : bp_lookup_if

// File: rtl/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor
    import isa_pkg::*, frontend_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    bp_lookup_if.responder  bp,

    input  logic            update_valid_i,
    input  logic [XLEN-1:0] update_pc_i,
    input  logic            update_taken_i,
    input  logic [XLEN-1:0] update_target_i,
    input  ghr_t            update_ghr_i,
    input  pht_ctr_t        update_pht_ctr_i,
    input  logic            update_pht_hit_i
);

    logic [XLEN-1:0]       btb_mem [BP_ENTRIES];   // target per branch pc
    pht_ctr_t              pht_mem [BP_ENTRIES];   // counter per history
    logic [BP_ENTRIES-1:0] btb_valid_q;
    logic [BP_ENTRIES-1:0] pht_valid_q;
    logic [BP_IDX_W-1:0]   lookup_idx;
    logic [BP_IDX_W-1:0]   update_idx;
    pht_ctr_t              pht_new;

    // word aligned pc so the low two bits are skipped
    assign lookup_idx = bp.lookup_pc[BP_IDX_W+1:2];
    assign update_idx = update_pc_i[BP_IDX_W+1:2];

    // training value for the pht entry
    always_comb begin
        if (!update_pht_hit_i) begin
            pht_new = update_taken_i ? PHT_WEAK_T : PHT_WEAK_NT;
        end else if (update_taken_i) begin
            pht_new = (update_pht_ctr_i == PHT_STRONG_T) ? update_pht_ctr_i
                                                         : update_pht_ctr_i + 2'd1;
        end else begin
            pht_new = (update_pht_ctr_i == PHT_STRONG_NT) ? update_pht_ctr_i
                                                          : update_pht_ctr_i - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (update_valid_i) begin
            pht_mem[update_ghr_i] <= pht_new;
            if (update_taken_i) begin
                btb_mem[update_idx] <= update_target_i;   // only taken branches
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            btb_valid_q <= '0;
            pht_valid_q <= '0;
        end else if (update_valid_i) begin
            pht_valid_q[update_ghr_i] <= 1'b1;
            if (update_taken_i) begin
                btb_valid_q[update_idx] <= 1'b1;
            end
        end
    end

    // lookup sees old table contents on a same-edge write
    always_ff @(posedge clk) begin
        if (bp.lookup_en) begin
            bp.btb_target <= btb_mem[lookup_idx];
            bp.pht_ctr    <= pht_mem[bp.lookup_ghr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bp.btb_hit <= 1'b0;
            bp.pht_hit <= 1'b0;
        end else if (bp.lookup_en) begin
            bp.btb_hit <= btb_valid_q[lookup_idx];
            bp.pht_hit <= pht_valid_q[bp.lookup_ghr];
        end
    end

    // fetch control must always drive a clean strobe
    lookup_en_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(bp.lookup_en)
    );

endmodule : branch_predictor

// File: rtl/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl
    import isa_pkg::*, frontend_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    bp_lookup_if.requester    bp,

    output logic              imem_req_valid_o,
    output logic [XLEN-1:0]   imem_req_addr_o,
    input  logic              imem_req_ready_i,
    input  logic              imem_resp_valid_i,
    input  logic [INST_W-1:0] imem_resp_inst_i,

    output logic              enq_valid_o,
    output fetch_pkt_t        enq_pkt_o,
    input  logic              queue_full_i,

    input  logic              redirect_i,
    input  logic [XLEN-1:0]   resolve_pc_i,
    input  logic              resolve_taken_i,
    input  logic [XLEN-1:0]   resolve_target_i,
    input  ghr_t              resolve_ghr_i
);

    fetch_state_e    state_q, state_d;
    logic [XLEN-1:0] pc_q, pc_d;
    ghr_t            ghr_q, ghr_d;
    logic            run_q;         // low during and right at reset
    logic            req_fire;
    logic            resp_live;
    opcode_e         resp_op;
    logic            is_branch;
    logic            pred_taken;
    logic [XLEN-1:0] redirect_pc;
    ghr_t            redirect_ghr;

    // queue cannot grow while idle, so valid holds until accepted
    assign imem_req_valid_o = run_q && (state_q == FETCH_IDLE) && !queue_full_i;
    assign imem_req_addr_o  = pc_q;
    assign req_fire         = imem_req_valid_o && imem_req_ready_i;

    assign bp.lookup_en  = req_fire;    // tables read on the accepting edge
    assign bp.lookup_pc  = pc_q;
    assign bp.lookup_ghr = ghr_q;

    assign resp_op    = opcode_e'(imem_resp_inst_i[OPCODE_W-1:0]);
    assign is_branch  = resp_op inside {op_jal, op_jalr, op_br};
    assign pred_taken = is_branch && bp.btb_hit && (!bp.pht_hit || bp.pht_ctr[1]);

    // a response racing a redirect is on the wrong path
    assign resp_live   = (state_q == FETCH_WAIT) && imem_resp_valid_i && !redirect_i;
    assign enq_valid_o = resp_live;

    always_comb begin
        enq_pkt_o.inst        = imem_resp_inst_i;
        enq_pkt_o.pc          = pc_q;           // still the requested address
        enq_pkt_o.pred_taken  = pred_taken;
        enq_pkt_o.pred_target = bp.btb_target;
        enq_pkt_o.pht_ctr     = bp.pht_ctr;
        enq_pkt_o.pht_hit     = bp.pht_hit;
        enq_pkt_o.ghr         = ghr_q;
    end

    assign redirect_pc  = resolve_taken_i ? resolve_target_i : resolve_pc_i + XLEN'(4);
    assign redirect_ghr = {resolve_ghr_i[GHR_W-2:0], resolve_taken_i};

    always_comb begin
        state_d = state_q;
        pc_d    = pc_q;
        ghr_d   = ghr_q;
        case (state_q)
            FETCH_IDLE: begin
                if (req_fire) begin
                    state_d = redirect_i ? FETCH_DROP : FETCH_WAIT;
                end
            end
            FETCH_WAIT: begin
                if (imem_resp_valid_i) begin
                    state_d = FETCH_IDLE;
                end else if (redirect_i) begin
                    state_d = FETCH_DROP;
                end
            end
            FETCH_DROP: begin
                if (imem_resp_valid_i) begin
                    state_d = FETCH_IDLE;   // stale response swallowed
                end
            end
            default: state_d = FETCH_IDLE;
        endcase

        if (resp_live) begin
            pc_d = pred_taken ? bp.btb_target : pc_q + XLEN'(4);
            if (is_branch) begin
                ghr_d = {ghr_q[GHR_W-2:0], pred_taken};
            end
        end

        // redirect wins over any prediction made this cycle
        if (redirect_i) begin
            pc_d  = redirect_pc;
            ghr_d = redirect_ghr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= FETCH_IDLE;
            pc_q    <= RESET_PC;
            ghr_q   <= '0;
            run_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
            ghr_q   <= ghr_d;
            run_q   <= 1'b1;
        end
    end

    // memory must only answer an accepted request
    resp_only_when_pending: assert property (
        @(posedge clk) disable iff (rst)
        !(imem_resp_valid_i && state_q == FETCH_IDLE)
    );

endmodule : fetch_ctrl

// File: rtl/fetch_frontend.sv
`timescale 1ns/1ps

module fetch_frontend
    import isa_pkg::*, frontend_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    output logic              imem_req_valid_o,
    output logic [XLEN-1:0]   imem_req_addr_o,
    input  logic              imem_req_ready_i,
    input  logic              imem_resp_valid_i,
    input  logic [INST_W-1:0] imem_resp_inst_i,

    output logic              out_valid_o,
    output logic [INST_W-1:0] out_inst_o,
    output logic [XLEN-1:0]   out_pc_o,
    output logic              out_pred_taken_o,
    output logic [XLEN-1:0]   out_pred_target_o,
    output pht_ctr_t          out_pht_ctr_o,
    output logic              out_pht_hit_o,
    output ghr_t              out_ghr_o,
    input  logic              out_ready_i,

    input  logic              resolve_valid_i,
    input  logic [XLEN-1:0]   resolve_pc_i,
    input  logic              resolve_taken_i,
    input  logic [XLEN-1:0]   resolve_target_i,
    input  logic              resolve_mispredict_i,
    input  ghr_t              resolve_ghr_i,
    input  pht_ctr_t          resolve_pht_ctr_i,
    input  logic              resolve_pht_hit_i
);

    logic       redirect;       // flush queue, restart fetch
    logic       enq_valid;
    fetch_pkt_t enq_pkt;
    logic       queue_full;
    fetch_pkt_t deq_pkt;

    bp_lookup_if bp_if ();

    assign redirect = resolve_valid_i && resolve_mispredict_i;

    fetch_ctrl u_fetch_ctrl (
        .clk               (clk),
        .rst               (rst),
        .bp                (bp_if.requester),
        .imem_req_valid_o  (imem_req_valid_o),
        .imem_req_addr_o   (imem_req_addr_o),
        .imem_req_ready_i  (imem_req_ready_i),
        .imem_resp_valid_i (imem_resp_valid_i),
        .imem_resp_inst_i  (imem_resp_inst_i),
        .enq_valid_o       (enq_valid),
        .enq_pkt_o         (enq_pkt),
        .queue_full_i      (queue_full),
        .redirect_i        (redirect),
        .resolve_pc_i      (resolve_pc_i),
        .resolve_taken_i   (resolve_taken_i),
        .resolve_target_i  (resolve_target_i),
        .resolve_ghr_i     (resolve_ghr_i)
    );

    branch_predictor u_branch_predictor (
        .clk              (clk),
        .rst              (rst),
        .bp               (bp_if.responder),
        .update_valid_i   (resolve_valid_i),     // every resolve trains
        .update_pc_i      (resolve_pc_i),
        .update_taken_i   (resolve_taken_i),
        .update_target_i  (resolve_target_i),
        .update_ghr_i     (resolve_ghr_i),
        .update_pht_ctr_i (resolve_pht_ctr_i),
        .update_pht_hit_i (resolve_pht_hit_i)
    );

    fetch_queue u_fetch_queue (
        .clk         (clk),
        .rst         (rst),
        .flush_i     (redirect),
        .enq_valid_i (enq_valid),
        .enq_pkt_i   (enq_pkt),
        .full_o      (queue_full),
        .deq_valid_o (out_valid_o),
        .deq_pkt_o   (deq_pkt),
        .deq_ready_i (out_ready_i)
    );

    // packet fields onto the back-end ports
    assign out_inst_o        = deq_pkt.inst;
    assign out_pc_o          = deq_pkt.pc;
    assign out_pred_taken_o  = deq_pkt.pred_taken;
    assign out_pred_target_o = deq_pkt.pred_target;
    assign out_pht_ctr_o     = deq_pkt.pht_ctr;
    assign out_pht_hit_o     = deq_pkt.pht_hit;
    assign out_ghr_o         = deq_pkt.ghr;

endmodule : fetch_frontend

// File: rtl/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue
    import frontend_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       flush_i,
    input  logic       enq_valid_i,
    input  fetch_pkt_t enq_pkt_i,
    output logic       full_o,
    output logic       deq_valid_o,
    output fetch_pkt_t deq_pkt_o,
    input  logic       deq_ready_i
);

    fetch_pkt_t             mem_q [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] head_q, tail_q;     // wrap naturally since depth is 2^n
    logic [QUEUE_CNT_W-1:0] count_q;
    logic                   deq_fire;

    assign full_o      = (count_q == QUEUE_CNT_W'(QUEUE_DEPTH));
    assign deq_valid_o = (count_q != '0);
    assign deq_pkt_o   = mem_q[head_q];
    assign deq_fire    = deq_valid_o && deq_ready_i;

    always_ff @(posedge clk) begin
        if (enq_valid_i) begin
            mem_q[tail_q] <= enq_pkt_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (enq_valid_i) begin
                tail_q <= tail_q + 1'b1;
            end
            if (deq_fire) begin
                head_q <= head_q + 1'b1;
            end
            case ({enq_valid_i, deq_fire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;     // both or neither
            endcase
        end
    end

    // an enqueue while full would overwrite the oldest entry
    no_enq_when_full: assert property (
        @(posedge clk) disable iff (rst)
        enq_valid_i |-> !full_o
    );

endmodule : fetch_queue

// File: rtl/frontend_pkg.sv
package frontend_pkg;

    import isa_pkg::*;

    localparam logic [XLEN-1:0] RESET_PC = 32'h1eceb000;   // first fetch address

    localparam int GHR_W       = 8;     // global history length
    localparam int BP_ENTRIES  = 256;   // btb and pht depth
    localparam int BP_IDX_W    = 8;     // index into both tables
    localparam int QUEUE_DEPTH = 32;    // fetch queue entries
    localparam int QUEUE_CNT_W = 6;     // holds 0 .. QUEUE_DEPTH
    localparam int QUEUE_PTR_W = 5;     // head and tail pointers

    // 2-bit saturating counter
    typedef logic [1:0] pht_ctr_t;

    localparam pht_ctr_t PHT_STRONG_NT = 2'b00;
    localparam pht_ctr_t PHT_WEAK_NT   = 2'b01;    // first not-taken write
    localparam pht_ctr_t PHT_WEAK_T    = 2'b10;    // first taken write
    localparam pht_ctr_t PHT_STRONG_T  = 2'b11;

    typedef logic [GHR_W-1:0] ghr_t;    // newest outcome in bit 0

    typedef enum logic [1:0] {
        FETCH_IDLE,     // no request outstanding
        FETCH_WAIT,     // request accepted, response expected
        FETCH_DROP      // outstanding response belongs to a squashed path
    } fetch_state_e;

    // one fetch queue entry that the back end returns on resolve
    typedef struct packed {
        logic [INST_W-1:0] inst;
        logic [XLEN-1:0]   pc;
        logic              pred_taken;
        logic [XLEN-1:0]   pred_target;   // btb target at lookup
        pht_ctr_t          pht_ctr;       // counter seen at lookup
        logic              pht_hit;
        ghr_t              ghr;           // history before this instruction
    } fetch_pkt_t;

endpackage : frontend_pkg

// File: rtl/isa_pkg.sv
package isa_pkg;

    localparam int XLEN     = 32;   // data and address width
    localparam int INST_W   = 32;   // one RV32I instruction
    localparam int OPCODE_W = 7;    // inst[6:0]

    // only the opcodes the front end cares about
    typedef enum logic [OPCODE_W-1:0] {
        op_jal  = 7'b1101111,       // unconditional jump
        op_jalr = 7'b1100111,       // indirect jump
        op_br   = 7'b1100011,       // conditional branch
        op_imm  = 7'b0010011        // alu with immediate
    } opcode_e;

endpackage : isa_pkg

// File: tb.f
rtl/isa_pkg.sv
rtl/frontend_pkg.sv
rtl/bp_lookup_if.sv
rtl/fetch_ctrl.sv
rtl/branch_predictor.sv
rtl/fetch_queue.sv
rtl/fetch_frontend.sv
testbench/tb_fetch_frontend.sv

// File: testbench/tb_fetch_frontend.sv
`timescale 1ns/1ps

module tb_fetch_frontend
    import isa_pkg::*, frontend_pkg::*;
();

    localparam logic [XLEN-1:0] BR_P = RESET_PC + 32'h100;     // the only branch address
    localparam logic [XLEN-1:0] BR_T = RESET_PC + 32'h800;     // its trained target
    localparam logic [XLEN-1:0] RED_T = RESET_PC + 32'h400;    // plain redirect target
    localparam ghr_t HIST_G = 8'h5a;                           // history seen at BR_P
    localparam ghr_t HIST_H = 8'h2d;                           // {HIST_H, 0} == HIST_G
    localparam int WATCHDOG_CYCLES = 3000;                     // all phases with slack

    logic clk, rst;
    logic imem_req_valid_o, imem_req_ready_i, imem_resp_valid_i;
    logic [XLEN-1:0] imem_req_addr_o;
    logic [INST_W-1:0] imem_resp_inst_i;
    logic out_valid_o, out_pred_taken_o, out_pht_hit_o, out_ready_i;
    logic [INST_W-1:0] out_inst_o;
    logic [XLEN-1:0] out_pc_o, out_pred_target_o;
    pht_ctr_t out_pht_ctr_o;
    ghr_t out_ghr_o;
    logic resolve_valid_i, resolve_taken_i, resolve_mispredict_i, resolve_pht_hit_i;
    logic [XLEN-1:0] resolve_pc_i, resolve_target_i;
    ghr_t resolve_ghr_i;
    pht_ctr_t resolve_pht_ctr_i;

    // resolve fields and ready level, applied at the next falling edge
    logic [XLEN-1:0] res_pc, res_tgt;
    logic res_taken, res_hit, ready_set = 1'b0;
    ghr_t res_ghr;
    pht_ctr_t res_ctr;

    // reference model state
    logic [31:0] lfsr = 32'h34a9572e;
    logic [XLEN-1:0] model_pc = RESET_PC;
    ghr_t model_ghr = '0;
    logic [XLEN-1:0] btb_tgt [BP_ENTRIES];
    logic btb_v [BP_ENTRIES];
    pht_ctr_t pht_c [BP_ENTRIES];
    logic pht_v [BP_ENTRIES];
    fetch_pkt_t expq [$];
    fetch_pkt_t pend_pkt, last_pkt;
    logic pend = 0, pend_drop = 0, pend_btb_hit = 0, res_pulse = 0, first_seen = 0;
    int pend_delay = 0, deq_count = 0;

    fetch_frontend uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run();
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic abort_with(string what);
        $display("%0t: %s", $time, what);
        stop_run();
    endtask

    task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
        assert (exp === act) else begin
            $display("** Error at %0t: %s expected %h got %h", $time, name, exp, act);
            stop_run();
        end
    endtask

    function automatic logic rand_bit();
        rand_bit = lfsr[0];
        lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);   // galois step
    endfunction

    function automatic logic [INST_W-1:0] mem_word(logic [XLEN-1:0] a);
        return (a == BR_P) ? {a[26:2], op_br} : {a[26:2], op_imm};
    endfunction

    // compare the dut packet with the expected one, then drop it
    task automatic take_packet();
        fetch_pkt_t p;
        p = expq.pop_front();
        check_val("out_inst_o", p.inst, out_inst_o);
        check_val("out_pc_o", p.pc, out_pc_o);
        check_val("out_pred_taken_o", p.pred_taken, out_pred_taken_o);
        check_val("out_pht_hit_o", p.pht_hit, out_pht_hit_o);
        check_val("out_ghr_o", p.ghr, out_ghr_o);
        if (p.pred_taken) check_val("out_pred_target_o", p.pred_target, out_pred_target_o);
        if (p.pht_hit) check_val("out_pht_ctr_o", p.pht_ctr, out_pht_ctr_o);
        last_pkt = p;
        deq_count++;
    endtask

    // drives on the falling edge and predicts the next rising edge
    task automatic cycle();
        fetch_pkt_t p;
        logic fire, mis, br;
        logic [1:0] d;
        @(negedge clk);
        imem_resp_valid_i = pend && pend_delay == 1;
        imem_resp_inst_i  = imem_resp_valid_i ? mem_word(pend_pkt.pc) : '0;
        imem_req_ready_i  = rand_bit();
        out_ready_i       = ready_set;
        resolve_valid_i   = res_pulse;
        if (res_pulse) begin
            resolve_pc_i         = res_pc;
            resolve_taken_i      = res_taken;
            resolve_target_i     = res_tgt;
            resolve_mispredict_i = 1'b1;
            resolve_ghr_i        = res_ghr;
            resolve_pht_ctr_i    = res_ctr;
            resolve_pht_hit_i    = res_hit;
        end
        res_pulse = 1'b0;
        #1;
        mis = resolve_valid_i && resolve_mispredict_i;
        assert (!(imem_req_valid_o && expq.size() == QUEUE_DEPTH))
            else abort_with("request raised while the fetch queue is full");
        if (imem_req_valid_o) check_val("imem_req_addr_o", model_pc, imem_req_addr_o);
        check_val("out_valid_o", expq.size() != 0, out_valid_o);
        if (out_valid_o && out_ready_i) take_packet();
        fire = imem_req_valid_o && imem_req_ready_i;
        if (fire && !first_seen) begin
            check_val("imem_req_addr_o", RESET_PC, imem_req_addr_o);
            first_seen = 1'b1;
        end
        if (imem_resp_valid_i) begin
            if (!pend_drop && !mis) begin
                p = pend_pkt;
                p.inst = imem_resp_inst_i;
                br = p.inst[6:0] inside {7'b1101111, 7'b1100111, 7'b1100011};
                p.pred_taken = br && pend_btb_hit && (!p.pht_hit || p.pht_ctr[1]);
                expq.push_back(p);
                model_pc = p.pred_taken ? p.pred_target : p.pc + 32'd4;
                if (br) model_ghr = {model_ghr[GHR_W-2:0], p.pred_taken};
            end
            pend = 1'b0;
        end else if (pend) begin
            pend_delay--;
            if (mis) pend_drop = 1'b1;
        end
        if (fire) begin
            d = {rand_bit(), rand_bit()};
            pend = 1'b1;
            pend_delay = 1 + d % 3;             // 1 to 3 cycles
            pend_drop = mis;
            pend_pkt = '0;
            pend_pkt.pc = model_pc;
            pend_pkt.ghr = model_ghr;
            pend_btb_hit = btb_v[model_pc[9:2]];
            pend_pkt.pred_target = btb_tgt[model_pc[9:2]];
            pend_pkt.pht_hit = pht_v[model_ghr];
            pend_pkt.pht_ctr = pht_c[model_ghr];
        end
        if (mis) begin
            expq.delete();
            model_pc = resolve_taken_i ? resolve_target_i : resolve_pc_i + 32'd4;
            model_ghr = {resolve_ghr_i[GHR_W-2:0], resolve_taken_i};
        end
        if (resolve_valid_i) begin
            if (!resolve_pht_hit_i)
                pht_c[resolve_ghr_i] = resolve_taken_i ? 2'b10 : 2'b01;
            else if (resolve_taken_i && resolve_pht_ctr_i != 2'b11)
                pht_c[resolve_ghr_i] = resolve_pht_ctr_i + 2'd1;
            else if (!resolve_taken_i && resolve_pht_ctr_i != 2'b00)
                pht_c[resolve_ghr_i] = resolve_pht_ctr_i - 2'd1;
            pht_v[resolve_ghr_i] = 1'b1;
            if (resolve_taken_i) begin
                btb_tgt[resolve_pc_i[9:2]] = resolve_target_i;
                btb_v[resolve_pc_i[9:2]] = 1'b1;
            end
        end
    endtask

    task automatic resolve(logic [XLEN-1:0] pc, logic taken, logic [XLEN-1:0] tgt,
                           ghr_t g, pht_ctr_t ctr, logic hit);
        res_pc = pc;
        res_taken = taken;
        res_tgt = tgt;
        res_ghr = g;
        res_ctr = ctr;
        res_hit = hit;
        res_pulse = 1'b1;
        cycle();
    endtask

    task automatic drain_packets(int n);
        int target;
        target = deq_count + n;
        while (deq_count < target) cycle();
    endtask

    task automatic wait_pc(logic [XLEN-1:0] pc);
        do drain_packets(1); while (last_pkt.pc != pc);
    endtask

    reset_quiet: assert property (@(negedge clk) rst |-> !imem_req_valid_o && !out_valid_o)
        else abort_with("request or packet valid during reset");

    req_held: assert property (@(posedge clk) disable iff (rst)
        imem_req_valid_o && !imem_req_ready_i && !resolve_valid_i
        |=> imem_req_valid_o && $stable(imem_req_addr_o))
        else abort_with("request dropped or changed before acceptance");

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("tests failed");
        $fatal(1, "timeout");
    end

    initial begin
        for (int i = 0; i < BP_ENTRIES; i++) begin
            btb_v[i] = 1'b0;
            pht_v[i] = 1'b0;
        end
        rst = 1'b1;
        imem_req_ready_i = 1'b0;
        imem_resp_valid_i = 1'b0;
        imem_resp_inst_i = '0;
        out_ready_i = 1'b0;
        resolve_valid_i = 1'b0;
        resolve_pc_i = '0;
        resolve_taken_i = 1'b0;
        resolve_target_i = '0;
        resolve_mispredict_i = 1'b0;
        resolve_ghr_i = '0;
        resolve_pht_ctr_i = '0;
        resolve_pht_hit_i = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        ready_set = 1'b1;                       // sequential fetch
        drain_packets(20);

        ready_set = 1'b0;                       // back-pressure until full
        while (expq.size() < QUEUE_DEPTH) cycle();
        repeat (20) cycle();
        ready_set = 1'b1;
        drain_packets(QUEUE_DEPTH);

        ready_set = 1'b0;                       // redirect with a response in flight
        repeat (6) cycle();
        while (!(pend && pend_delay > 1 && expq.size() != 0)) cycle();
        resolve(RESET_PC, 1'b1, RED_T, 8'h33, 2'b00, 1'b0);
        ready_set = 1'b1;
        drain_packets(1);
        check_val("out_pc_o", RED_T, last_pkt.pc);
        check_val("out_ghr_o", 8'h67, last_pkt.ghr);

        resolve(BR_P, 1'b1, BR_T, HIST_G, 2'b00, 1'b0);     // train taken
        resolve(BR_P - 32'd4, 1'b0, '0, HIST_H, 2'b00, 1'b0);
        wait_pc(BR_P);
        check_val("out_pred_taken_o", 1, last_pkt.pred_taken);
        drain_packets(1);
        check_val("out_pc_o", BR_T, last_pkt.pc);

        resolve(BR_P, 1'b0, '0, HIST_G, 2'b10, 1'b1);      // counter down to weak not-taken
        resolve(BR_P - 32'd4, 1'b0, '0, HIST_H, 2'b00, 1'b0);
        wait_pc(BR_P);
        check_val("out_pred_taken_o", 0, last_pkt.pred_taken);
        check_val("out_pht_ctr_o", 2'b01, last_pkt.pht_ctr);
        drain_packets(1);
        check_val("out_pc_o", BR_P + 32'd4, last_pkt.pc);

        repeat (10) cycle();
        $display("all tests passed");
        $finish;
    end

endmodule : tb_fetch_frontend
